// ==== src.f ====
pet_spi_pkg.sv
spi_byte.sv
sync_edge.sv
spi_echo_ctrl.sv
pet_spi_top.sv
tb_pet_spi.sv

// ==== Makefile ====
# Verilator build and run of the SPI echo link testbench
# Override any variable on the command line, e.g. make run LOG=run1.log

VERILATOR   ?= verilator
TOP         ?= tb_pet_spi
FILELIST    ?= src.f
OBJ_DIR     ?= obj_dir
LOG         ?= sim.log
JOBS        ?= 0
VFLAGS      ?= --binary --timing -j $(JOBS)
EXTRA_FLAGS ?=

FAIL_MSG := Test failures found

# Sources come from the file list so the binary tracks every edit
SRCS := $(filter %.sv %.v,$(shell cat $(FILELIST)))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) $(EXTRA_FLAGS) \
		--top-module $(TOP) \
		--Mdir $(OBJ_DIR) \
		-f $(FILELIST)

# The log decides the result, a crash with no message also fails
run: $(BIN)
	@./$(BIN) > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi; \
	if [ $$status -ne 0 ]; then \
		echo "Simulator exited with status $$status"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== tb_pet_spi.sv ====
// --------------------
// Testbench for the SPI echo link with an SPI mode 0 host on clk_sys_i
// Ready checks 6 cycles after an edge hold for SYNC_STAGES 2 only
// Random bytes and lengths from a Galois LFSR with a fixed seed
// --------------------

`timescale 1ns/10ps

module tb_pet_spi;

    localparam int unsigned SYNC_STAGES = 2;

    // Host timing in system cycles
    localparam int HALF_CYCLES = 6;
    localparam int GAP_CYCLES  = 10;
    localparam int IDLE_CYCLES = 8;

    // Test sizes
    localparam int NUM_RANDOM_XFERS = 12;
    localparam int NUM_ABORTS       = 6;
    localparam int MAX_BYTES        = 4;

    // Timeout worked out from the longest transfer
    localparam int BYTE_CYCLES     = 16 * HALF_CYCLES + (GAP_CYCLES - HALF_CYCLES);
    localparam int XFER_OVERHEAD   = HALF_CYCLES + IDLE_CYCLES + 6;
    localparam int MAX_XFER_CYCLES = MAX_BYTES * BYTE_CYCLES + XFER_OVERHEAD;
    localparam int NUM_XFERS       = 1 + NUM_RANDOM_XFERS + 2 * NUM_ABORTS + 2;
    localparam int TIMEOUT_CYCLES  = 2 * NUM_XFERS * MAX_XFER_CYCLES;

    localparam logic [31:0] LFSR_SEED = 32'ha0e3;
    // x^32 + x^22 + x^2 + x + 1
    localparam logic [31:0] LFSR_TAPS = 32'h80200003;

    logic clk_sys_i;
    logic rst_i;
    logic spi_sck_i;
    logic spi_cs_ni;
    logic spi_rx_i;
    logic spi_tx_o;
    logic spi_ready_o;

    // Model state
    pet_spi_pkg::spi_byte_t    exp_echo;
    pet_spi_pkg::ready_state_e exp_ready;

    logic [31:0] lfsr_q;
    int          err_count;
    int          check_count;
    int          cycle_cnt = 0;

    pet_spi_top #(
        .SYNC_STAGES (SYNC_STAGES)
    ) dut (
        .clk_sys_i   (clk_sys_i),
        .rst_i       (rst_i),
        .spi_sck_i   (spi_sck_i),
        .spi_cs_ni   (spi_cs_ni),
        .spi_rx_i    (spi_rx_i),
        .spi_tx_o    (spi_tx_o),
        .spi_ready_o (spi_ready_o)
    );

    // 100 MHz system clock
    initial begin
        clk_sys_i = 1'b0;
        forever begin
            #5 clk_sys_i = ~clk_sys_i;
        end
    end

    // Run limit
    always @(posedge clk_sys_i) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not end within %0d cycles", TIMEOUT_CYCLES);
            $display("Test failures found");
            $finish;
        end
    end

    // Galois step shifts right and folds the taps in when bit 0 drops out
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ LFSR_TAPS;
        end
        return state >> 1;
    endfunction

    // One LFSR step per bit taken
    task automatic take_bits(input int n, output logic [31:0] value);
        value = '0;
        for (int k = 0; k < n; k++) begin
            value  = {value[30:0], lfsr_q[0]};
            lfsr_q = lfsr_next(lfsr_q);
        end
    endtask

    task automatic check_byte(
        input pet_spi_pkg::spi_byte_t got,
        input pet_spi_pkg::spi_byte_t exp,
        input string                  what
    );
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("[FAIL] %0t: %s got 8'h%02h expected 8'h%02h", $time, what, got, exp);
        end
    endtask

    task automatic check_ready(
        input pet_spi_pkg::ready_state_e got,
        input pet_spi_pkg::ready_state_e exp,
        input string                     what
    );
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("[FAIL] %0t: %s got %s expected %s",
                     $time, what, got.name(), exp.name());
        end
    endtask

    // Every host task starts and ends just after a rising clock edge
    task automatic idle(input int n);
        repeat (n) @(posedge clk_sys_i);
    endtask

    // Ready flag sampled mid-cycle on the falling clock edge
    task automatic sample_ready(output pet_spi_pkg::ready_state_e rdy);
        @(negedge clk_sys_i);
        rdy = pet_spi_pkg::ready_state_e'(spi_ready_o);
        @(posedge clk_sys_i);
    endtask

    // First nbits of one mode 0 byte slot in MSB-first order
    // MISO is read just before each SCK rise and ready just before each fall
    task automatic shift_bits(
        input  pet_spi_pkg::spi_byte_t    tx,
        input  int                        nbits,
        output pet_spi_pkg::spi_byte_t    rx,
        output pet_spi_pkg::ready_state_e rdy
    );
        logic [2:0] bit_idx;
        rx  = '0;
        rdy = pet_spi_pkg::READY_IDLE;
        for (int k = 0; k < nbits; k++) begin
            bit_idx = 3'(7 - k);
            spi_rx_i <= tx[bit_idx];
            // SCK low phase
            repeat (HALF_CYCLES - 1) @(posedge clk_sys_i);
            @(negedge clk_sys_i);
            rx[bit_idx] = spi_tx_o;
            @(posedge clk_sys_i);
            spi_sck_i <= 1'b1;
            // SCK high phase
            repeat (HALF_CYCLES - 1) @(posedge clk_sys_i);
            sample_ready(rdy);
            spi_sck_i <= 1'b0;
        end
    endtask

    task automatic begin_transfer();
        spi_cs_ni <= 1'b0;
    endtask

    // Release chip select and expect the ready flag to drop
    task automatic end_transfer();
        pet_spi_pkg::ready_state_e rdy;
        spi_cs_ni <= 1'b1;
        spi_rx_i  <= 1'b0;
        exp_ready = pet_spi_pkg::READY_IDLE;
        idle(HALF_CYCLES - 1);
        sample_ready(rdy);
        check_ready(rdy, exp_ready, "ready after chip select release");
        idle(IDLE_CYCLES);
    endtask

    // Each random byte returns the previous slot's byte
    task automatic send_bytes(input int nbytes);
        logic [31:0]               value;
        pet_spi_pkg::spi_byte_t    tx;
        pet_spi_pkg::spi_byte_t    rx;
        pet_spi_pkg::ready_state_e rdy;
        for (int b = 0; b < nbytes; b++) begin
            take_bits(8, value);
            tx = value[7:0];
            shift_bits(tx, 8, rx, rdy);
            check_byte(rx, exp_echo, "returned byte");
            exp_echo  = tx;
            exp_ready = pet_spi_pkg::READY_SET;
            check_ready(rdy, exp_ready, "ready after byte");
            // Rest of the inter-byte gap with SCK low
            idle(GAP_CYCLES - HALF_CYCLES);
        end
    endtask

    task automatic run_transfer(input int nbytes);
        begin_transfer();
        send_bytes(nbytes);
        end_transfer();
    endtask

    task automatic apply_reset();
        rst_i <= 1'b1;
        idle(2);
        rst_i <= 1'b0;
        exp_echo  = pet_spi_pkg::ECHO_RESET_BYTE;
        exp_ready = pet_spi_pkg::READY_IDLE;
    endtask

    task automatic report_test(input string name, input int errs_before, input int checks_before);
        $display("Test %s finished: %0d checks, %0d errors",
                 name, check_count - checks_before, err_count - errs_before);
    endtask

    // Reset value and idle ready flag
    task automatic test_reset_value();
        int                        errs_before;
        int                        checks_before;
        pet_spi_pkg::ready_state_e rdy;
        errs_before   = err_count;
        checks_before = check_count;
        sample_ready(rdy);
        check_ready(rdy, exp_ready, "ready before any transfer");
        run_transfer(1);
        report_test("reset_value", errs_before, checks_before);
    endtask

    // Multi-byte transfers carry the echo across chip select releases
    task automatic test_random_transfers();
        int          errs_before;
        int          checks_before;
        logic [31:0] value;
        errs_before   = err_count;
        checks_before = check_count;
        for (int t = 0; t < NUM_RANDOM_XFERS; t++) begin
            take_bits(2, value);
            run_transfer(int'(value[1:0]) + 1);
        end
        report_test("random_transfers", errs_before, checks_before);
    endtask

    // Short transfers of 1 to 7 bits followed by a normal byte that checks the echo
    task automatic test_aborts();
        int                        errs_before;
        int                        checks_before;
        int                        nbits;
        logic [31:0]               value;
        pet_spi_pkg::spi_byte_t    rx;
        pet_spi_pkg::spi_byte_t    mask;
        pet_spi_pkg::ready_state_e rdy;
        errs_before   = err_count;
        checks_before = check_count;
        for (int a = 0; a < NUM_ABORTS; a++) begin
            take_bits(3, value);
            nbits = (int'(value[2:0]) % 7) + 1;
            take_bits(8, value);
            begin_transfer();
            shift_bits(value[7:0], nbits, rx, rdy);
            // Bits shifted out so far are the top of the echo byte
            mask = 8'hFF << (8 - nbits);
            check_byte(rx, exp_echo & mask, "bits returned in aborted transfer");
            // Nothing completed so the flag must not have moved
            check_ready(rdy, exp_ready, "ready during aborted transfer");
            idle(GAP_CYCLES - HALF_CYCLES);
            end_transfer();
            run_transfer(1);
        end
        report_test("aborted_transfers", errs_before, checks_before);
    endtask

    // Reset in the middle of a byte slot once rx_valid has fallen
    task automatic test_reset_after_traffic();
        int                        errs_before;
        int                        checks_before;
        pet_spi_pkg::spi_byte_t    rx;
        pet_spi_pkg::ready_state_e rdy;
        errs_before   = err_count;
        checks_before = check_count;
        begin_transfer();
        send_bytes(2);
        shift_bits(8'h5A, 3, rx, rdy);
        check_byte(rx, exp_echo & 8'hE0, "bits returned before reset");
        apply_reset();
        idle(HALF_CYCLES - 1);
        sample_ready(rdy);
        check_ready(rdy, exp_ready, "ready after reset");
        end_transfer();
        run_transfer(1);
        report_test("reset_after_traffic", errs_before, checks_before);
    endtask

    initial begin
        lfsr_q      = LFSR_SEED;
        err_count   = 0;
        check_count = 0;
        exp_echo    = pet_spi_pkg::ECHO_RESET_BYTE;
        exp_ready   = pet_spi_pkg::READY_IDLE;

        // Idle bus with reset held for two cycles
        rst_i     <= 1'b1;
        spi_sck_i <= 1'b0;
        spi_cs_ni <= 1'b1;
        spi_rx_i  <= 1'b0;
        idle(2);
        rst_i <= 1'b0;
        idle(IDLE_CYCLES);

        test_reset_value();
        test_random_transfers();
        test_aborts();
        test_reset_after_traffic();

        $display("Summary: %0d checks, %0d errors", check_count, err_count);
        if (err_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// ==== pet_spi_top.sv ====
// --------------------
// SPI echo link, top level
// Host keeps each SCK half-period at least SYNC_STAGES+2 system cycles
// and SCK low at least SYNC_STAGES+4 cycles between bytes
// --------------------

`timescale 1ns/10ps

module pet_spi_top #(
    parameter int unsigned SYNC_STAGES = 2
) (
    input  logic clk_sys_i,
    input  logic rst_i,

    // SPI from the host microcontroller
    input  logic spi_sck_i,
    input  logic spi_cs_ni,
    input  logic spi_rx_i,
    output logic spi_tx_o,

    // High from a completed byte until chip select rises
    output logic spi_ready_o
);

    // SCK domain
    logic                   rx_valid;
    pet_spi_pkg::spi_byte_t rx_byte;

    // System domain
    pet_spi_pkg::spi_byte_t tx_byte;
    logic                   byte_done;
    logic                   cs_release;

    spi_byte u_spi_byte (
        .spi_sck_i  (spi_sck_i),
        .spi_cs_ni  (spi_cs_ni),
        .spi_rx_i   (spi_rx_i),
        .spi_tx_o   (spi_tx_o),
        .rx_valid_o (rx_valid),
        .rx_byte_o  (rx_byte),
        .tx_byte_i  (tx_byte)
    );

    // End of byte into clk_sys_i
    sync_edge #(
        .SYNC_STAGES (SYNC_STAGES)
    ) rx_valid_sync (
        .clk_sys_i (clk_sys_i),
        .rst_i     (rst_i),
        .level_i   (rx_valid),
        .pulse_o   (byte_done)
    );

    // Chip select release into clk_sys_i
    sync_edge #(
        .SYNC_STAGES (SYNC_STAGES)
    ) cs_sync (
        .clk_sys_i (clk_sys_i),
        .rst_i     (rst_i),
        .level_i   (spi_cs_ni),
        .pulse_o   (cs_release)
    );

    spi_echo_ctrl u_echo_ctrl (
        .clk_sys_i    (clk_sys_i),
        .rst_i        (rst_i),
        .byte_done_i  (byte_done),
        .cs_release_i (cs_release),
        .rx_byte_i    (rx_byte),
        .tx_byte_o    (tx_byte),
        .spi_ready_o  (spi_ready_o)
    );

endmodule

// ==== spi_echo_ctrl.sv ====
// --------------------
// Echo byte and ready flag in the system clock domain
// No back-pressure, a new byte simply replaces the echo byte
// byte_done_i wins over cs_release_i in the same cycle
// --------------------

`timescale 1ns/10ps

module spi_echo_ctrl (
    input  logic                   clk_sys_i,
    input  logic                   rst_i,

    // Pulses from the synchronizers
    input  logic                   byte_done_i,
    input  logic                   cs_release_i,

    // Byte from the SPI target, stable around byte_done_i
    input  pet_spi_pkg::spi_byte_t rx_byte_i,

    // Byte returned in the next slot
    output pet_spi_pkg::spi_byte_t tx_byte_o,
    output logic                   spi_ready_o
);

    pet_spi_pkg::ready_state_e state_q;
    pet_spi_pkg::ready_state_e state_d;

    pet_spi_pkg::spi_byte_t    echo_q;

    // Ready flag FSM
    always_comb begin
        state_d = state_q;
        case (state_q)
            pet_spi_pkg::READY_IDLE: begin
                if (byte_done_i) begin
                    state_d = pet_spi_pkg::READY_SET;
                end
            end
            pet_spi_pkg::READY_SET: begin
                // Another byte in the same transfer keeps it set
                if (!byte_done_i && cs_release_i) begin
                    state_d = pet_spi_pkg::READY_IDLE;
                end
            end
            default: begin
                state_d = pet_spi_pkg::READY_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_sys_i) begin
        if (rst_i) begin
            state_q <= pet_spi_pkg::READY_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Echo byte
    // Starts at the reset value so the host can spot a live link
    always_ff @(posedge clk_sys_i) begin
        if (rst_i) begin
            echo_q <= pet_spi_pkg::ECHO_RESET_BYTE;
        end else if (byte_done_i) begin
            echo_q <= rx_byte_i;
        end
    end

    assign tx_byte_o   = echo_q;
    assign spi_ready_o = (state_q == pet_spi_pkg::READY_SET);

endmodule

// ==== sync_edge.sv ====
// --------------------
// Level synchronizer into clk_sys_i with rising-edge pulse
// SYNC_STAGES must be 2 or more
// Input pulses shorter than about SYNC_STAGES+2 cycles may be missed
// --------------------

`timescale 1ns/10ps

module sync_edge #(
    parameter int unsigned SYNC_STAGES = 2
) (
    input  logic clk_sys_i,
    input  logic rst_i,
    input  logic level_i,
    output logic pulse_o
);

    // Synchronizer chain, bit 0 sees the asynchronous input
    logic [SYNC_STAGES-1:0] sync_q;

    // Synchronized level from the previous cycle
    logic                   prev_q;

    always_ff @(posedge clk_sys_i) begin
        if (rst_i) begin
            sync_q <= '0;
            prev_q <= 1'b0;
        end else begin
            sync_q <= {sync_q[SYNC_STAGES-2:0], level_i};
            prev_q <= sync_q[SYNC_STAGES-1];
        end
    end

    // One cycle high on a low-to-high transition of the synced level
    assign pulse_o = sync_q[SYNC_STAGES-1] & ~prev_q;

endmodule

// ==== spi_byte.sv ====
// --------------------
// SPI target, mode 0, MSB first, one byte per slot
// Runs entirely on the host's SCK, chip select clears it asynchronously
// tx_byte_i must be stable before the first SCK rising edge of a byte
// --------------------

`timescale 1ns/10ps

module spi_byte (
    // SPI pins from the host
    input  logic                  spi_sck_i,
    input  logic                  spi_cs_ni,
    input  logic                  spi_rx_i,
    output logic                  spi_tx_o,

    // Received byte, level in the SCK domain
    output logic                  rx_valid_o,
    output pet_spi_pkg::spi_byte_t rx_byte_o,

    // Byte to return during the current slot
    input  pet_spi_pkg::spi_byte_t tx_byte_i
);

    // Bit position within the byte, 0 before the first rising edge
    logic [2:0] bit_cnt_q;

    // First seven received bits, the eighth comes straight from MOSI
    logic [6:0] rx_shift_q;

    // Transmit bit registered on the falling edge
    logic       tx_bit_q;

    // Counter and valid flag
    // Both are held clear while chip select is high
    always_ff @(posedge spi_sck_i or posedge spi_cs_ni) begin
        if (spi_cs_ni) begin
            bit_cnt_q  <= 3'd0;
            rx_valid_o <= 1'b0;
        end else begin
            // Wraps from 7 to 0 at the end of each byte
            bit_cnt_q  <= bit_cnt_q + 3'd1;
            // High for one SCK period after the eighth bit
            rx_valid_o <= (bit_cnt_q == 3'd7);
        end
    end

    // Receive path, MOSI sampled on the rising edge
    always_ff @(posedge spi_sck_i) begin
        rx_shift_q <= {rx_shift_q[5:0], spi_rx_i};
        // Completed byte, held until the next byte completes
        // so it stays stable long after rx_valid_o falls
        if (bit_cnt_q == 3'd7) begin
            rx_byte_o <= {rx_shift_q, spi_rx_i};
        end
    end

    // Transmit path, next bit set up on the falling edge
    // Counter k selects bit 7-k, which is the inverted counter
    always_ff @(negedge spi_sck_i) begin
        tx_bit_q <= tx_byte_i[~bit_cnt_q];
    end

    // Bit 7 has no falling edge ahead of it
    // so it passes through while the counter is at zero
    assign spi_tx_o = (bit_cnt_q == 3'd0) ? tx_byte_i[7] : tx_bit_q;

endmodule

// ==== pet_spi_pkg.sv ====
// --------------------
// Shared types and constants of the SPI echo link
// ECHO_RESET_BYTE is what the host reads before any byte has arrived
// --------------------

package pet_spi_pkg;

    // Width of one SPI data byte
    localparam int unsigned SPI_BYTE_W = 8;

    // One byte as shifted over MOSI or MISO, MSB first
    typedef logic [SPI_BYTE_W-1:0] spi_byte_t;

    // Byte returned before the first complete byte
    // Host checks for this value to confirm the link is alive
    localparam spi_byte_t ECHO_RESET_BYTE = 8'hEE;

    // State of the ready flag seen by the host
    // READY_SET from the end of a byte until chip select is released
    typedef enum logic {
        READY_IDLE = 1'b0,
        READY_SET  = 1'b1
    } ready_state_e;

endpackage
